/* Makefile */
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/Vtb_apb_subsystem: flist.f *.sv
	verilator --binary --timing --assert -j 0 --top-module tb_apb_subsystem -f flist.f

run: obj_dir/Vtb_apb_subsystem
	./obj_dir/Vtb_apb_subsystem | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

lint:
	verilator --lint-only --timing -Wall --top-module apb_subsystem_top -f flist.f

clean:
	rm -rf obj_dir $(LOG)

/* apb_addr_decoder.sv */
`default_nettype none

module apb_addr_decoder (
    input  wire logic [apb_pkg::ADDR_WIDTH-1:0] paddr,
    output logic      [apb_pkg::NUM_SLAVES-1:0] sel,
    output logic                                miss
);

    logic found;

    // Windows are checked in order, only the first hit is flagged
    always_comb begin
        sel   = '0;
        found = 1'b0;
        for (int j = 0; j < apb_pkg::NUM_SLAVES; j++) begin
            if (!found &&
                (paddr >= apb_pkg::SLAVE_BASE[j]) &&
                (paddr <= apb_pkg::SLAVE_LIMIT[j])) begin
                sel[j] = 1'b1;
                found  = 1'b1;
            end
        end
    end

    assign miss = !found;  // Outside every window

endmodule

`default_nettype wire

/* apb_crossbar.sv */
`default_nettype none

module apb_crossbar #(
    parameter int NUM_MASTERS = 2
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire apb_pkg::apb_req_t m_req [NUM_MASTERS],
    output apb_pkg::apb_rsp_t      m_rsp [NUM_MASTERS],
    output apb_pkg::apb_req_t      s_req [apb_pkg::NUM_SLAVES],
    input  wire apb_pkg::apb_rsp_t s_rsp [apb_pkg::NUM_SLAVES]
);

    logic [apb_pkg::NUM_SLAVES-1:0] dec_sel   [NUM_MASTERS];
    logic [NUM_MASTERS-1:0]         dec_miss;
    logic [NUM_MASTERS-1:0]         arb_req   [apb_pkg::NUM_SLAVES];
    logic [NUM_MASTERS-1:0]         arb_grant [apb_pkg::NUM_SLAVES];
    logic [apb_pkg::NUM_SLAVES-1:0] arb_done;

    // One decoder per master
    for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_dec
        apb_addr_decoder i_dec (
            .paddr (m_req[i].paddr),
            .sel   (dec_sel[i]),
            .miss  (dec_miss[i])
        );
    end

    // Request vector of each slave, one bit per master
    always_comb begin
        for (int j = 0; j < apb_pkg::NUM_SLAVES; j++) begin
            for (int i = 0; i < NUM_MASTERS; i++) begin
                arb_req[j][i] = m_req[i].psel && dec_sel[i][j];
            end
        end
    end

    // One arbiter per slave port
    for (genvar j = 0; j < apb_pkg::NUM_SLAVES; j++) begin : g_arb
        apb_slave_arbiter #(
            .NUM_MASTERS (NUM_MASTERS)
        ) i_arb (
            .clk       (clk),
            .rst       (rst),
            .req       (arb_req[j]),
            .slave_rsp (s_rsp[j]),
            .m_req     (m_req),
            .slave_req (s_req[j]),
            .grant     (arb_grant[j]),
            .done      (arb_done[j])
        );
    end

    // Response steering back to the masters
    always_comb begin
        for (int i = 0; i < NUM_MASTERS; i++) begin
            m_rsp[i] = '0;  // Stall unless something below answers

            // Error responder for unmapped addresses
            if (m_req[i].psel && m_req[i].penable && dec_miss[i]) begin
                m_rsp[i].pready  = 1'b1;
                m_rsp[i].pslverr = 1'b1;
            end

            // Only the grantee sees its slave, and only when it finishes
            for (int j = 0; j < apb_pkg::NUM_SLAVES; j++) begin
                if (arb_grant[j][i] && arb_done[j]) begin
                    m_rsp[i] = s_rsp[j];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* apb_pkg.sv */
`default_nettype none

package apb_pkg;

    // Bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // Number of windows in the address map
    localparam int NUM_SLAVES = 3;

    // Slave port index of each device
    localparam int SLV_REG   = 0;
    localparam int SLV_RAM_A = 1;
    localparam int SLV_RAM_B = 2;

    // Inclusive windows, first match wins
    localparam logic [ADDR_WIDTH-1:0] SLAVE_BASE [NUM_SLAVES] = '{
        32'h0000_0000,  // Registers
        32'h0000_1000,  // RAM A
        32'h0000_2000   // RAM B
    };
    localparam logic [ADDR_WIDTH-1:0] SLAVE_LIMIT [NUM_SLAVES] = '{
        32'h0000_000F,
        32'h0000_1FFF,
        32'h0000_2FFF
    };

    // Value of the read-only ID register
    localparam logic [DATA_WIDTH-1:0] REG_ID_VALUE = 32'hA9B0_0001;

    // Request from a master, or from the crossbar toward a slave
    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [ADDR_WIDTH-1:0] paddr;
        logic [DATA_WIDTH-1:0] pwdata;
        logic [STRB_WIDTH-1:0] pstrb;
    } apb_req_t;

    typedef struct packed {
        logic                  pready;
        logic [DATA_WIDTH-1:0] prdata;
        logic                  pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        ARB_IDLE   = 2'd0,
        ARB_SETUP  = 2'd1,  // Registered setup after a handover
        ARB_ACCESS = 2'd2
    } arb_state_e;

endpackage

`default_nettype wire

/* apb_ram_slave.sv */
`default_nettype none

module apb_ram_slave #(
    parameter int WAIT_STATES = 0,
    parameter int DEPTH_WORDS = 1024
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire apb_pkg::apb_req_t req,
    output apb_pkg::apb_rsp_t      rsp
);

    localparam int IDX_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;
    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [apb_pkg::DATA_WIDTH-1:0] mem [DEPTH_WORDS];
    logic [apb_pkg::ADDR_WIDTH-3:0] word_addr;
    logic [IDX_W-1:0]               word_idx;
    logic [CNT_W-1:0]               wait_cnt;
    logic                           access;
    logic                           ready;

    assign access    = req.psel && req.penable;
    assign word_addr = req.paddr[apb_pkg::ADDR_WIDTH-1:2];   // Drop byte offset
    assign word_idx  = IDX_W'(word_addr % DEPTH_WORDS);      // Wraps inside the window
    assign ready     = access && (wait_cnt == CNT_W'(WAIT_STATES));

    always_comb begin
        rsp         = '0;
        rsp.pready  = ready;
        rsp.prdata  = (access && !req.pwrite) ? mem[word_idx] : '0;
        rsp.pslverr = 1'b0;  // Never errors
    end

    // Counts access cycles until pready
    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (!access || ready) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ready && req.pwrite) begin
            for (int b = 0; b < apb_pkg::STRB_WIDTH; b++) begin
                if (req.pstrb[b]) begin
                    mem[word_idx][8*b +: 8] <= req.pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* apb_reg_slave.sv */
`default_nettype none

module apb_reg_slave (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire apb_pkg::apb_req_t req,
    output apb_pkg::apb_rsp_t      rsp
);

    localparam int NUM_RW = 3;  // Offsets 0x0, 0x4, 0x8

    logic [apb_pkg::DATA_WIDTH-1:0] regs [NUM_RW];
    logic [1:0]                     offset;
    logic                           access;
    logic                           id_sel;

    assign access = req.psel && req.penable;
    assign offset = req.paddr[3:2];
    assign id_sel = (offset == 2'd3);  // 0xC is the ID

    // No wait states, answers in the first access cycle
    always_comb begin
        rsp         = '0;
        rsp.pready  = access;
        rsp.pslverr = access && req.pwrite && id_sel;
        if (access && !req.pwrite) begin
            if (id_sel) begin
                rsp.prdata = apb_pkg::REG_ID_VALUE;
            end
            for (int r = 0; r < NUM_RW; r++) begin
                if (offset == 2'(r)) begin
                    rsp.prdata = regs[r];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NUM_RW; r++) begin
                regs[r] <= '0;
            end
        end else if (access && req.pwrite && !id_sel) begin
            for (int r = 0; r < NUM_RW; r++) begin
                for (int b = 0; b < apb_pkg::STRB_WIDTH; b++) begin
                    if (offset == 2'(r) && req.pstrb[b]) begin
                        regs[r][8*b +: 8] <= req.pwdata[8*b +: 8];  // Byte lane
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* apb_slave_arbiter.sv */
`default_nettype none

module apb_slave_arbiter #(
    parameter int NUM_MASTERS = 2
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [NUM_MASTERS-1:0] req,
    input  wire apb_pkg::apb_rsp_t    slave_rsp,
    input  wire apb_pkg::apb_req_t    m_req [NUM_MASTERS],
    output apb_pkg::apb_req_t         slave_req,
    output logic [NUM_MASTERS-1:0]    grant,
    output logic                      done
);

    localparam int IDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

    apb_pkg::arb_state_e    state;
    logic [IDX_W-1:0]       gnt_idx_q;  // Current grantee, also the round-robin pointer
    logic [NUM_MASTERS-1:0] cand_mask;
    logic [IDX_W-1:0]       pick_idx;
    logic                   pick_any;
    logic [IDX_W-1:0]       cur_idx;
    logic                   active;

    // While a transfer runs, the grantee itself is not a candidate
    assign cand_mask = (state == apb_pkg::ARB_ACCESS) ?
                       (req & ~(NUM_MASTERS'(1) << gnt_idx_q)) : req;

    // Search starts just after the last grantee
    always_comb begin
        pick_any = 1'b0;
        pick_idx = '0;
        for (int k = 1; k <= NUM_MASTERS; k++) begin
            if (!pick_any && cand_mask[(int'(gnt_idx_q) + k) % NUM_MASTERS]) begin
                pick_any = 1'b1;
                pick_idx = IDX_W'((int'(gnt_idx_q) + k) % NUM_MASTERS);
            end
        end
    end

    assign active  = (state != apb_pkg::ARB_IDLE) || pick_any;
    assign cur_idx = (state == apb_pkg::ARB_IDLE) ? pick_idx : gnt_idx_q;
    assign done    = (state == apb_pkg::ARB_ACCESS) && slave_rsp.pready;

    // Grantee's request toward the slave, phases generated here
    always_comb begin
        slave_req = '0;
        grant     = '0;
        if (active) begin
            slave_req         = m_req[cur_idx];
            slave_req.psel    = 1'b1;
            slave_req.penable = (state == apb_pkg::ARB_ACCESS);
            grant[cur_idx]    = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= apb_pkg::ARB_IDLE;
            gnt_idx_q <= IDX_W'(NUM_MASTERS - 1);  // Master 0 wins first
        end else begin
            case (state)
                apb_pkg::ARB_IDLE: begin
                    if (pick_any) begin
                        state     <= apb_pkg::ARB_ACCESS;
                        gnt_idx_q <= pick_idx;
                    end
                end
                apb_pkg::ARB_SETUP: state <= apb_pkg::ARB_ACCESS;
                apb_pkg::ARB_ACCESS: begin
                    if (done) begin
                        if (pick_any) begin
                            // Waiting master, replay its setup next cycle
                            state     <= apb_pkg::ARB_SETUP;
                            gnt_idx_q <= pick_idx;
                        end else begin
                            state <= apb_pkg::ARB_IDLE;
                        end
                    end
                end
                default: state <= apb_pkg::ARB_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* apb_subsystem_top.sv */
`default_nettype none

module apb_subsystem_top #(
    parameter int NUM_MASTERS   = 2,
    parameter int WAIT_STATES_A = 0,
    parameter int WAIT_STATES_B = 2,
    parameter int DEPTH_WORDS   = 1024
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire apb_pkg::apb_req_t m_req [NUM_MASTERS],
    output apb_pkg::apb_rsp_t      m_rsp [NUM_MASTERS]
);

    apb_pkg::apb_req_t s_req [apb_pkg::NUM_SLAVES];
    apb_pkg::apb_rsp_t s_rsp [apb_pkg::NUM_SLAVES];

    apb_crossbar #(
        .NUM_MASTERS (NUM_MASTERS)
    ) i_xbar (
        .clk   (clk),
        .rst   (rst),
        .m_req (m_req),
        .m_rsp (m_rsp),
        .s_req (s_req),
        .s_rsp (s_rsp)
    );

    apb_reg_slave i_regs (
        .clk (clk),
        .rst (rst),
        .req (s_req[apb_pkg::SLV_REG]),
        .rsp (s_rsp[apb_pkg::SLV_REG])
    );

    // Fast RAM
    apb_ram_slave #(
        .WAIT_STATES (WAIT_STATES_A),
        .DEPTH_WORDS (DEPTH_WORDS)
    ) i_ram_a (
        .clk (clk),
        .rst (rst),
        .req (s_req[apb_pkg::SLV_RAM_A]),
        .rsp (s_rsp[apb_pkg::SLV_RAM_A])
    );

    apb_ram_slave #(
        .WAIT_STATES (WAIT_STATES_B),  // Slow RAM
        .DEPTH_WORDS (DEPTH_WORDS)
    ) i_ram_b (
        .clk (clk),
        .rst (rst),
        .req (s_req[apb_pkg::SLV_RAM_B]),
        .rsp (s_rsp[apb_pkg::SLV_RAM_B])
    );

endmodule

`default_nettype wire

/* flist.f */
apb_pkg.sv
apb_addr_decoder.sv
apb_slave_arbiter.sv
apb_crossbar.sv
apb_reg_slave.sv
apb_ram_slave.sv
apb_subsystem_top.sv
tb_apb_subsystem.sv

/* tb_apb_subsystem.sv */
`default_nettype none

module tb_apb_subsystem;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_MASTERS   = 2;
    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 16;
    localparam int XFER_LIMIT    = 32;  // Cycles before a transfer counts as hung
    localparam int NUM_RAM_WORDS = 6;
    localparam int NUM_TRANSFERS = 63;
    localparam int WORST_CYCLES  = 10;  // Contended RAM B transfer plus idle gap
    localparam int WATCHDOG_NS   = 2 * (RESET_CYCLES + NUM_TRANSFERS * WORST_CYCLES) * CLK_PERIOD;
    localparam logic [31:0] MISS_ADDR [3] = '{32'h0000_0010, 32'h0000_3000, 32'hFFFF_FFF0};

    logic              clk = 1'b0;
    logic              rst;
    apb_pkg::apb_req_t m_req [NUM_MASTERS];
    apb_pkg::apb_rsp_t m_rsp [NUM_MASTERS];

    int    seed = 8256;
    int    errors;
    int    test_err_start;
    int    tests_passed;
    int    tests_failed;
    string test_name;

    logic [31:0] reg_model [3];
    logic [31:0] ram_model [2][1024];  // Index 0 is RAM A
    logic [31:0] ram_addrs [NUM_RAM_WORDS];
    logic [31:0] rd  [NUM_MASTERS];
    logic        er  [NUM_MASTERS];
    int          cyc [NUM_MASTERS];

    apb_subsystem_top #(
        .NUM_MASTERS   (NUM_MASTERS),
        .WAIT_STATES_A (0),
        .WAIT_STATES_B (2),
        .DEPTH_WORDS   (1024)
    ) i_dut (
        .clk   (clk),
        .rst   (rst),
        .m_req (m_req),
        .m_rsp (m_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [3:0] partial_strobe();
        logic [3:0] s;
        s = 4'($random(seed));
        if (s == 4'h0 || s == 4'hF) begin
            s = 4'b0110;  // Keep it partial
        end
        return s;
    endfunction

    task automatic check_equal(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("mismatch in %s, %s: expected 0x%08h, actual 0x%08h",
                     test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("error in %s: %s", test_name, what);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name      = name;
        test_err_start = errors;
    endtask

    task automatic finish_test();
        if (errors == test_err_start) begin
            tests_passed++;
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - test_err_start);
        end
    endtask

    // One APB transfer with cycles counted from the setup edge to the edge after pready
    task automatic run_transfer(input int m, input logic wr, input logic [31:0] addr,
                                input logic [31:0] wdata, input logic [3:0] strb,
                                output logic [31:0] rdata, output logic err,
                                output int cycles);
        apb_pkg::apb_req_t r;
        logic              seen;
        r        = '0;
        r.psel   = 1'b1;
        r.pwrite = wr;
        r.paddr  = addr;
        r.pwdata = wdata;
        r.pstrb  = wr ? strb : 4'h0;
        @(posedge clk);
        m_req[m] <= r;  // Setup
        @(posedge clk);
        r.penable = 1'b1;
        m_req[m] <= r;  // Access
        cycles = 1;
        @(negedge clk);
        while (!m_rsp[m].pready && cycles < XFER_LIMIT) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        seen  = m_rsp[m].pready;
        rdata = m_rsp[m].prdata;
        err   = m_rsp[m].pslverr;
        @(posedge clk);
        cycles++;
        m_req[m] <= '0;
        check_true(seen, $sformatf("master %0d transfer to 0x%08h never completed", m, addr));
    endtask

    task automatic write_word(input int m, input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input logic exp_err,
                              input int exp_cycles, input string what);
        logic [31:0] rdata;
        logic        err;
        int          cycles;
        run_transfer(m, 1'b1, addr, data, strb, rdata, err, cycles);
        check_equal({what, " pslverr"}, 32'(exp_err), 32'(err));
        check_equal({what, " cycles"}, 32'(exp_cycles), 32'(cycles));
    endtask

    task automatic read_word(input int m, input logic [31:0] addr, input logic [31:0] exp_data,
                             input logic exp_err, input int exp_cycles, input string what);
        logic [31:0] rdata;
        logic        err;
        int          cycles;
        run_transfer(m, 1'b0, addr, 32'h0, 4'h0, rdata, err, cycles);
        check_equal({what, " prdata"}, exp_data, rdata);
        check_equal({what, " pslverr"}, 32'(exp_err), 32'(err));
        check_equal({what, " cycles"}, 32'(exp_cycles), 32'(cycles));
    endtask

    // Winner takes the plain latency and the other master finishes strictly later
    task automatic check_contention(input int lat, input int winner);
        check_equal("winner cycles", 32'(lat), 32'(cyc[winner]));
        check_true(cyc[1 - winner] > cyc[winner], "waiting master finished before the winner");
        check_equal("pslverr master 0", 32'h0, 32'(er[0]));
        check_equal("pslverr master 1", 32'h0, 32'(er[1]));
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] base;
        logic [31:0] d0;
        logic [31:0] d1;
        logic [3:0]  strb;
        int          lat;
        int          last_b;
        int          winner;
        rst = 1'b1;
        for (int i = 0; i < NUM_MASTERS; i++) begin
            m_req[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        start_test("reset");
        @(negedge clk);
        for (int i = 0; i < NUM_MASTERS; i++) begin
            check_equal("pready after reset", 32'h0, 32'(m_rsp[i].pready));
        end
        for (int j = 0; j < apb_pkg::NUM_SLAVES; j++) begin
            check_equal("slave psel after reset", 32'h0, 32'(i_dut.s_req[j].psel));
            check_equal("slave penable after reset", 32'h0, 32'(i_dut.s_req[j].penable));
        end
        finish_test();

        start_test("reg_strobes");
        for (int r = 0; r < 3; r++) begin
            addr = 32'(r * 4);
            read_word(0, addr, 32'h0, 1'b0, 2, "reset value");
            data = $random(seed);
            write_word(r % 2, addr, data, 4'hF, 1'b0, 2, "full write");
            reg_model[r] = data;
            data = $random(seed);
            strb = partial_strobe();
            write_word(r % 2, addr, data, strb, 1'b0, 2, "partial write");
            reg_model[r] = merge_bytes(reg_model[r], data, strb);
            read_word((r + 1) % 2, addr, reg_model[r], 1'b0, 2, "merged read");
        end
        finish_test();

        start_test("id_register");
        read_word(0, 32'h0000_000C, apb_pkg::REG_ID_VALUE, 1'b0, 2, "id read");
        data = $random(seed);
        write_word(1, 32'h0000_000C, data, 4'hF, 1'b1, 2, "id write");
        read_word(1, 32'h0000_000C, apb_pkg::REG_ID_VALUE, 1'b0, 2, "id read after write");
        read_word(0, 32'h0000_0008, reg_model[2], 1'b0, 2, "neighbour register");
        finish_test();

        start_test("rams");
        last_b = 0;
        for (int ram = 0; ram < 2; ram++) begin
            base = (ram == 0) ? 32'h0000_1000 : 32'h0000_2000;
            lat  = (ram == 0) ? 2 : 4;  // RAM B adds two wait states
            for (int k = 0; k < NUM_RAM_WORDS; k++) begin
                ram_addrs[k] = base | (32'($random(seed)) & 32'h0000_0FFC);
                data = $random(seed);
                write_word(k % 2, ram_addrs[k], data, 4'hF, 1'b0, lat, "ram full write");
                ram_model[ram][ram_addrs[k][11:2]] = data;
            end
            for (int k = 0; k < NUM_RAM_WORDS; k++) begin
                data = $random(seed);
                strb = partial_strobe();
                write_word(k % 2, ram_addrs[k], data, strb, 1'b0, lat, "ram partial write");
                ram_model[ram][ram_addrs[k][11:2]] =
                    merge_bytes(ram_model[ram][ram_addrs[k][11:2]], data, strb);
            end
            for (int k = 0; k < NUM_RAM_WORDS; k++) begin
                read_word((k + 1) % 2, ram_addrs[k], ram_model[ram][ram_addrs[k][11:2]],
                          1'b0, lat, "ram read");
                if (ram == 1) begin
                    last_b = (k + 1) % 2;  // Last master granted by the RAM B arbiter
                end
            end
        end
        finish_test();

        start_test("unmapped");
        for (int k = 0; k < 3; k++) begin
            run_transfer(k % 2, k == 1, MISS_ADDR[k], 32'hDEAD_BEEF, 4'hF, rd[0], er[0], cyc[0]);
            check_equal("miss pslverr", 32'h1, 32'(er[0]));
            check_equal("miss prdata", 32'h0, rd[0]);
            check_equal("miss cycles", 32'h2, 32'(cyc[0]));
        end
        finish_test();

        start_test("contention");
        d0 = $random(seed);
        d1 = $random(seed);
        winner = 1 - last_b;  // Round-robin starts after the last grantee
        fork
            run_transfer(0, 1'b1, 32'h0000_2040, d0, 4'hF, rd[0], er[0], cyc[0]);
            run_transfer(1, 1'b1, 32'h0000_2080, d1, 4'hF, rd[1], er[1], cyc[1]);
        join
        check_contention(4, winner);
        last_b = 1 - winner;  // Waiting master was served last
        ram_model[1][10'h010] = d0;  // 0x2040
        ram_model[1][10'h020] = d1;  // 0x2080
        winner = 1 - last_b;
        fork
            run_transfer(0, 1'b0, 32'h0000_2080, 32'h0, 4'h0, rd[0], er[0], cyc[0]);
            run_transfer(1, 1'b0, 32'h0000_2040, 32'h0, 4'h0, rd[1], er[1], cyc[1]);
        join
        check_contention(4, winner);
        check_equal("read by master 0", ram_model[1][10'h020], rd[0]);
        check_equal("read by master 1", ram_model[1][10'h010], rd[1]);
        finish_test();

        start_test("parallel");
        d0 = $random(seed);
        d1 = $random(seed);
        fork
            run_transfer(0, 1'b1, 32'h0000_0004, d0, 4'hF, rd[0], er[0], cyc[0]);
            run_transfer(1, 1'b1, 32'h0000_1100, d1, 4'hF, rd[1], er[1], cyc[1]);
        join
        check_equal("register write cycles", 32'h2, 32'(cyc[0]));
        check_equal("ram write cycles", 32'h2, 32'(cyc[1]));
        reg_model[1]          = d0;
        ram_model[0][10'h040] = d1;  // 0x1100
        fork
            run_transfer(0, 1'b0, 32'h0000_0004, 32'h0, 4'h0, rd[0], er[0], cyc[0]);
            run_transfer(1, 1'b0, 32'h0000_1100, 32'h0, 4'h0, rd[1], er[1], cyc[1]);
        join
        check_equal("register read cycles", 32'h2, 32'(cyc[0]));
        check_equal("ram read cycles", 32'h2, 32'(cyc[1]));
        check_equal("register read data", reg_model[1], rd[0]);
        check_equal("ram read data", ram_model[0][10'h040], rd[1]);
        finish_test();

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
